//--- all.f
logic/red_pkg.sv
logic/red_sum_tree.sv
logic/red_max_tree.sv
logic/red_accumulator.sv
logic/red_top.sv
testbench/tb_clock_gen.sv
testbench/red_props.sv
testbench/red_tb.sv

//--- logic/red_accumulator.sv
`timescale 1ns/1ps

module red_accumulator #(
    parameter int DATA_W = red_pkg::DEF_DATA_W,
    parameter int BEATS  = red_pkg::DEF_BEATS
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] sum_i,
    input  logic              sum_valid_i,
    input  logic [DATA_W-1:0] max_i,
    input  logic              max_valid_i,
    output logic [DATA_W-1:0] result_o,
    output logic              done_o
);
    import red_pkg::*;

    localparam int CNT_W = $clog2(BEATS);

    // Beats already folded in this reduction
    logic [CNT_W-1:0]  beat_cnt;
    // Running value
    logic [DATA_W-1:0] acc_q;

    red_op_e           fold_op;
    logic              in_valid;
    logic [DATA_W-1:0] in_val;
    logic [DATA_W-1:0] fold_val;
    logic              first_beat;
    logic              last_beat;

    // ------------------------------------------------------------------------
    // Input select and fold
    // ------------------------------------------------------------------------

    // At most one tree reports per cycle
    assign in_valid = sum_valid_i | max_valid_i;
    assign fold_op  = max_valid_i ? OP_MAX : OP_SUM;
    assign in_val   = (fold_op == OP_MAX) ? max_i : sum_i;

    always_comb begin
        if (fold_op == OP_MAX) begin
            fold_val = (acc_q > in_val) ? acc_q : in_val;
        end else begin
            // Wrapping add
            fold_val = acc_q + in_val;
        end
    end

    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == CNT_W'(BEATS - 1));

    // ------------------------------------------------------------------------
    // Running value
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (in_valid) begin
            // First result loads, later ones fold
            acc_q <= first_beat ? in_val : fold_val;
        end
    end

    // ------------------------------------------------------------------------
    // Beat count, result and done
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            result_o <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (in_valid) begin
                if (last_beat) begin
                    // Final value out, counter ready for next reduction
                    beat_cnt <= '0;
                    result_o <= fold_val;
                    done_o   <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/red_max_tree.sv
`timescale 1ns/1ps

module red_max_tree #(
    parameter int LANES  = red_pkg::DEF_LANES,
    parameter int DATA_W = red_pkg::DEF_DATA_W
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en_i,
    input  logic [LANES*DATA_W-1:0] beat_i,
    output logic [DATA_W-1:0]       max_o,
    output logic                    valid_o
);
    import red_pkg::*;

    // Same depth as the sum tree
    localparam int LEVELS = $clog2(LANES);

    // Node storage, root at the top index
    logic [DATA_W-1:0] node_q [LANES-1];
    logic              vld_q  [LEVELS];

    for (genvar lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
        localparam int NODES = LANES >> lvl;
        localparam int BASE  = LANES - ((2 * LANES) >> lvl);

        logic lvl_en;

        if (lvl == 1) begin : g_first
            assign lvl_en = en_i;
        end else begin : g_inner
            // Follows the level below
            assign lvl_en = vld_q[lvl-2];
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                vld_q[lvl-1] <= 1'b0;
            end else begin
                vld_q[lvl-1] <= lvl_en;
            end
        end

        for (genvar n = 0; n < NODES; n++) begin : g_node
            logic [DATA_W-1:0] op_a;
            logic [DATA_W-1:0] op_b;

            if (lvl == 1) begin : g_leaf
                assign op_a = beat_i[(2*n)*DATA_W +: DATA_W];
                assign op_b = beat_i[(2*n+1)*DATA_W +: DATA_W];
            end else begin : g_pair
                localparam int PBASE = LANES - ((4 * LANES) >> lvl);
                assign op_a = node_q[PBASE + 2*n];
                assign op_b = node_q[PBASE + 2*n + 1];
            end

            // Unsigned compare, larger one kept
            always_ff @(posedge clk) begin
                if (lvl_en) begin
                    node_q[BASE + n] <= (op_a > op_b) ? op_a : op_b;
                end
            end
        end
    end

    assign max_o   = node_q[LANES-2];
    assign valid_o = vld_q[LEVELS-1];

endmodule

//--- logic/red_pkg.sv
package red_pkg;

    // ------------------------------------------------------------------------
    // Reduction operation
    // ------------------------------------------------------------------------

    // One bit, held by the source for a whole reduction
    typedef enum logic {
        OP_SUM = 1'b0,
        OP_MAX = 1'b1
    } red_op_e;

    // ------------------------------------------------------------------------
    // Default sizes
    // ------------------------------------------------------------------------

    // Elements per beat, power of two
    localparam int DEF_LANES  = 8;
    // Element width in bits
    localparam int DEF_DATA_W = 16;
    // Beats folded into one result
    localparam int DEF_BEATS  = 4;

endpackage

//--- logic/red_sum_tree.sv
`timescale 1ns/1ps

module red_sum_tree #(
    parameter int LANES  = red_pkg::DEF_LANES,
    parameter int DATA_W = red_pkg::DEF_DATA_W
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en_i,
    input  logic [LANES*DATA_W-1:0] beat_i,
    output logic [DATA_W-1:0]       sum_o,
    output logic                    valid_o
);
    import red_pkg::*;

    // One register stage per tree level
    localparam int LEVELS = $clog2(LANES);

    // Internal nodes, level by level, root last
    logic [DATA_W-1:0] node_q [LANES-1];
    // Valid bit beside each level
    logic              vld_q  [LEVELS];

    for (genvar lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
        localparam int NODES = LANES >> lvl;
        localparam int BASE  = LANES - ((2 * LANES) >> lvl);

        logic lvl_en;

        // First level runs on the beat strobe
        if (lvl == 1) begin : g_first
            assign lvl_en = en_i;
        end else begin : g_inner
            assign lvl_en = vld_q[lvl-2];
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                vld_q[lvl-1] <= 1'b0;
            end else begin
                vld_q[lvl-1] <= lvl_en;
            end
        end

        for (genvar n = 0; n < NODES; n++) begin : g_node
            logic [DATA_W-1:0] op_a;
            logic [DATA_W-1:0] op_b;

            if (lvl == 1) begin : g_leaf
                // Adjacent lanes of the beat
                assign op_a = beat_i[(2*n)*DATA_W +: DATA_W];
                assign op_b = beat_i[(2*n+1)*DATA_W +: DATA_W];
            end else begin : g_pair
                localparam int PBASE = LANES - ((4 * LANES) >> lvl);
                assign op_a = node_q[PBASE + 2*n];
                assign op_b = node_q[PBASE + 2*n + 1];
            end

            // Wraps modulo 2**DATA_W, carry dropped
            always_ff @(posedge clk) begin
                if (lvl_en) begin
                    node_q[BASE + n] <= op_a + op_b;
                end
            end
        end
    end

    assign sum_o   = node_q[LANES-2];
    assign valid_o = vld_q[LEVELS-1];

endmodule

//--- logic/red_top.sv
`timescale 1ns/1ps

module red_top #(
    parameter int LANES  = red_pkg::DEF_LANES,
    parameter int DATA_W = red_pkg::DEF_DATA_W,
    parameter int BEATS  = red_pkg::DEF_BEATS
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    beat_valid_i,
    input  red_pkg::red_op_e        op_i,
    input  logic [LANES*DATA_W-1:0] beat_i,
    output logic [DATA_W-1:0]       result_o,
    output logic                    done_o
);
    import red_pkg::*;

    // Tree enables
    logic              sum_en;
    logic              max_en;
    // Tree results
    logic [DATA_W-1:0] sum_val;
    logic              sum_vld;
    logic [DATA_W-1:0] max_val;
    logic              max_vld;

    // Only the selected tree sees the beat
    assign sum_en = beat_valid_i && (op_i == OP_SUM);
    assign max_en = beat_valid_i && (op_i == OP_MAX);

    // ------------------------------------------------------------------------
    // Reduction trees
    // ------------------------------------------------------------------------

    red_sum_tree #(.LANES(LANES), .DATA_W(DATA_W)) i_sum_tree (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (sum_en),
        .beat_i  (beat_i),
        .sum_o   (sum_val),
        .valid_o (sum_vld)
    );

    red_max_tree #(.LANES(LANES), .DATA_W(DATA_W)) i_max_tree (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (max_en),
        .beat_i  (beat_i),
        .max_o   (max_val),
        .valid_o (max_vld)
    );

    // Folds BEATS tree results per reduction
    red_accumulator #(.DATA_W(DATA_W), .BEATS(BEATS)) i_accumulator (
        .clk         (clk),
        .rst_n       (rst_n),
        .sum_i       (sum_val),
        .sum_valid_i (sum_vld),
        .max_i       (max_val),
        .max_valid_i (max_vld),
        .result_o    (result_o),
        .done_o      (done_o)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the reduction unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module red_tb -f all.f --Mdir obj_dir -o red_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/red_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$sim_out"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

//--- testbench/red_input.txt
// Record: header word pair (op 0=sum 1=max, expected result), then 4 beats
// Beat line: 8 hex lanes, lane 0 first
// Sum wrapping past 16 bits
0000 91BC
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
0001 0002 0003 0004 0005 0006 0007 0008
8000 8000 8000 8000 8000 8000 8000 8000
1234 1234 1234 1234 1234 1234 1234 1234
// Max with the winner in the last beat
0001 FFFE
0100 0200 0300 0400 0500 0600 0700 0800
1111 2222 3333 4444 5555 6666 7777 7FFF
8000 0001 8001 0002 0003 0004 0005 0006
0000 0000 0000 0000 0000 0000 FFFE 0000
// Max with the winner in the first beat
0001 F00D
0010 0020 0030 F00D 0040 0050 0060 0070
7000 7001 7002 7003 7004 7005 7006 7007
EFFF 0001 0002 0003 0004 0005 0006 0007
1000 1000 1000 1000 1000 1000 1000 1000
// All-zero lanes
0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
// Sum wrapping to a small value
0000 0008
00FF 00FF 00FF 00FF 00FF 00FF 00FF 00FF
FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00
4000 4000 4000 4000 4000 4000 4000 4000
0002 0002 0002 0002 0002 0002 0002 0002

//--- testbench/red_props.sv
`timescale 1ns/1ps

module red_props (
    input logic clk,
    input logic rst_n,
    input logic sum_valid_i,
    input logic max_valid_i,
    input logic done_o
);

    // ------------------------------------------------------------------------
    // Tree result strobes
    // ------------------------------------------------------------------------

    // Only the selected tree reports in a given cycle
    a_one_tree : assert property (
        @(posedge clk) disable iff (!rst_n) !(sum_valid_i && max_valid_i)
    ) else $error("sum and max tree results arrived in the same cycle");

    // ------------------------------------------------------------------------
    // Done strobe
    // ------------------------------------------------------------------------

    // Single-cycle pulse
    a_done_pulse : assert property (
        @(posedge clk) disable iff (!rst_n) done_o |=> !done_o
    ) else $error("done_o stayed high for more than one cycle");

    // Cleared by reset
    a_done_reset : assert property (
        @(posedge clk) !rst_n |=> !done_o
    ) else $error("done_o high while reset asserted");

endmodule

//--- testbench/red_tb.sv
`timescale 1ns/1ps

module red_tb;
    import red_pkg::*;

    localparam int LANES     = DEF_LANES;
    localparam int DATA_W    = DEF_DATA_W;
    localparam int BEATS     = DEF_BEATS;
    localparam int NUM_RECS  = 5;
    // Header word pair, then all lanes of all beats
    localparam int REC_WORDS = 2 + BEATS * LANES;
    // Cycles from a beat on the bus to done_o
    localparam int DONE_LAT  = 4;
    localparam int TIMEOUT   = 200;

    logic                    clk;
    logic                    rst_n;
    logic                    beat_valid_i;
    red_op_e                 op_i;
    logic [LANES*DATA_W-1:0] beat_i;
    logic [DATA_W-1:0]       result_o;
    logic                    done_o;

    logic [DATA_W-1:0] stim_mem [0:NUM_RECS*REC_WORDS-1];
    // Expected results and done cycles in arrival order
    logic [DATA_W-1:0] exp_val_q [$];
    int                exp_cyc_q [$];

    int cycle = 0;
    int seed;
    int mismatch_cnt;
    int timeout_cnt;
    int error_cnt;
    int done_seen;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(10)) i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    red_top #(.LANES(LANES), .DATA_W(DATA_W), .BEATS(BEATS)) i_red_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_valid_i (beat_valid_i),
        .op_i         (op_i),
        .beat_i       (beat_i),
        .result_o     (result_o),
        .done_o       (done_o)
    );

    bind red_accumulator red_props i_red_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .sum_valid_i (sum_valid_i),
        .max_valid_i (max_valid_i),
        .done_o      (done_o)
    );

    // Edge counter for latency checks
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------------------
    // Reference model and stimulus
    // ------------------------------------------------------------------------

    // Wrapping sum or unsigned max over every element of a record
    function automatic logic [DATA_W-1:0] reduce_record(input int rec);
        int                base;
        logic [DATA_W-1:0] acc;
        logic [DATA_W-1:0] elem;
        base = rec * REC_WORDS;
        acc  = '0;
        for (int i = 0; i < BEATS * LANES; i++) begin
            elem = stim_mem[base + 2 + i];
            if (stim_mem[base][0]) begin
                if (elem > acc) begin
                    acc = elem;
                end
            end else begin
                acc = acc + elem;
            end
        end
        return acc;
    endfunction

    // Expected values in the file must agree with the model
    task automatic check_file();
        int base;
        for (int r = 0; r < NUM_RECS; r++) begin
            base = r * REC_WORDS;
            if (stim_mem[base] > 1) begin
                $display("ERROR: record %0d has an unknown operation code %h", r, stim_mem[base]);
                error_cnt++;
            end
            if (reduce_record(r) != stim_mem[base + 1]) begin
                $display("ERROR: record %0d expected value %h in the input file, model gives %h",
                         r, stim_mem[base + 1], reduce_record(r));
                error_cnt++;
            end
        end
    endtask

    task automatic drive_record(input int rec, input bit gapped);
        int base;
        int gap;
        base = rec * REC_WORDS;
        for (int b = 0; b < BEATS; b++) begin
            gap = gapped ? int'($unsigned($random(seed)) % 4) : 0;
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                #2;
                beat_valid_i = 1'b0;
            end
            @(posedge clk);
            #2;
            beat_valid_i = 1'b1;
            op_i         = red_op_e'(stim_mem[base][0]);
            for (int k = 0; k < LANES; k++) begin
                beat_i[k*DATA_W +: DATA_W] = stim_mem[base + 2 + b * LANES + k];
            end
        end
        // Last beat is on the bus this cycle
        exp_val_q.push_back(stim_mem[base + 1]);
        exp_cyc_q.push_back(cycle + DONE_LAT);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #2;
        beat_valid_i = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (done_seen < target && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (done_seen < target) begin
            $display("TIMEOUT: no done_o after %0d cycles, %0d of %0d results seen",
                     TIMEOUT, done_seen, target);
            timeout_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Result collector
    // ------------------------------------------------------------------------

    initial begin : collect
        logic [DATA_W-1:0] exp_val;
        int                exp_cyc;
        forever begin
            // Sample mid-cycle where outputs are settled
            @(negedge clk);
            if (rst_n && done_o) begin
                done_seen++;
                if (exp_val_q.size() == 0) begin
                    $display("ERROR at %0t: done_o pulsed with no reduction outstanding", $time);
                    error_cnt++;
                end else begin
                    exp_val = exp_val_q.pop_front();
                    exp_cyc = exp_cyc_q.pop_front();
                    if (result_o != exp_val) begin
                        $display("MISMATCH time=%0t signal=result_o expected=%h actual=%h",
                                 $time, exp_val, result_o);
                        mismatch_cnt++;
                    end
                    if (cycle != exp_cyc) begin
                        $display("MISMATCH time=%0t signal=done_o cycle expected=%0d actual=%0d",
                                 $time, exp_cyc, cycle);
                        mismatch_cnt++;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin : main
        int waited;
        beat_valid_i = 1'b0;
        op_i         = OP_SUM;
        beat_i       = '0;
        seed         = 14;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        error_cnt    = 0;
        done_seen    = 0;

        $readmemh("testbench/red_input.txt", stim_mem);
        check_file();

        waited = 0;
        while (rst_n !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("TIMEOUT: reset still asserted after %0d cycles", TIMEOUT);
            timeout_cnt++;
        end

        // Quiet outputs before any beat
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (done_o !== 1'b0) begin
                $display("MISMATCH time=%0t signal=done_o expected=0 actual=%b", $time, done_o);
                mismatch_cnt++;
            end
            if (result_o !== '0) begin
                $display("MISMATCH time=%0t signal=result_o expected=%h actual=%h",
                         $time, {DATA_W{1'b0}}, result_o);
                mismatch_cnt++;
            end
        end

        // Back to back records with sum to max and max to sum switches
        for (int r = 0; r < NUM_RECS; r++) begin
            drive_record(r, 1'b0);
        end
        go_idle();
        wait_results(NUM_RECS);

        // Same records with random idle gaps between beats
        for (int r = 0; r < NUM_RECS; r++) begin
            drive_record(r, 1'b1);
        end
        go_idle();
        wait_results(2 * NUM_RECS);

        // Catch any stray pulse
        repeat (10) @(posedge clk);
        if (done_seen != 2 * NUM_RECS) begin
            $display("ERROR: saw %0d done_o pulses, %0d reductions were driven",
                     done_seen, 2 * NUM_RECS);
            error_cnt++;
        end

        $display("Summary: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatch_cnt, timeout_cnt, error_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0 && error_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock, low first
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held for a fixed number of edges, released just after an edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule
